/* dv/tb_vector_ex.sv */
module tb_vector_ex import rvv_ex_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES = 4;
    localparam int WAIT_LIMIT = 40;

    typedef word_t [NUM_LANES-1:0] vec_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 in_valid;
    valuop_t              valuop;
    vreg_sel_t            vd_sel;
    vreg_sel_t            vs1_sel;
    vreg_sel_t            vs2_sel;
    logic                 use_rs1;
    logic                 use_imm;
    logic [4:0]           imm;
    word_t                rdat1;
    logic                 mask_en;
    logic                 is_unsigned;
    logic                 stall;
    logic                 flush;
    logic                 out_valid;
    vreg_sel_t            out_vd;
    vec_t                 out_result;
    logic [NUM_LANES-1:0] out_lane_mask;

    // reference copy of every bank register
    vec_t                 shadow [32];
    word_t                rng = 33106;
    logic                 stall_q = 1'b0;

    vreg_sel_t            exp_vd [$];
    vec_t                 exp_res [$];
    logic [NUM_LANES-1:0] exp_mask [$];
    vreg_sel_t            got_vd [$];
    vec_t                 got_res [$];
    logic [NUM_LANES-1:0] got_mask [$];

    vector_ex_datapath #(
        .NUM_LANES (NUM_LANES)
    ) i_dut (
        .CLK           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .valuop        (valuop),
        .vd_sel        (vd_sel),
        .vs1_sel       (vs1_sel),
        .vs2_sel       (vs2_sel),
        .use_rs1       (use_rs1),
        .use_imm       (use_imm),
        .imm           (imm),
        .rdat1         (rdat1),
        .mask_en       (mask_en),
        .is_unsigned   (is_unsigned),
        .stall         (stall),
        .flush         (flush),
        .out_valid     (out_valid),
        .out_vd        (out_vd),
        .out_result    (out_result),
        .out_lane_mask (out_lane_mask)
    );

    always #2 clk = ~clk;

    task automatic fail_stop();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    // outputs are stable at the falling edge
    // a held out_valid during stall is the same result, so only count fresh ones
    always @(negedge clk) begin
        if (reset) begin
            check_value("out_valid", 32'h0, word_t'(out_valid));
        end else if (out_valid && !stall_q) begin
            got_vd.push_back(out_vd);
            got_res.push_back(out_result);
            got_mask.push_back(out_lane_mask);
        end
        stall_q = stall;
    end

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [4:0] rand_imm();
        word_t r;
        r = next_rand();
        return r[4:0];
    endfunction

    function automatic vec_t predict(input valuop_t op, input vec_t a, input vec_t b,
                                     input vec_t old, input logic [NUM_LANES-1:0] m,
                                     input logic uns);
        vec_t                 r;
        word_t                w;
        word_t                e;
        word_t                pad;
        word_t                acc;
        logic [NUM_LANES-1:0] bits;
        logic                 lt;
        r = old;
        bits = '0;
        acc = b[0];
        // identity for lanes that are masked off in a fold
        pad = (op == VALU_REDMAX && !uns) ? 32'h8000_0000 : 32'h0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lt = uns ? (a[i] < b[i]) : ($signed(a[i]) < $signed(b[i]));
            case (op)
                VALU_ADD: w = a[i] + b[i];
                VALU_SUB: w = a[i] - b[i];
                VALU_AND: w = a[i] & b[i];
                VALU_OR:  w = a[i] | b[i];
                VALU_XOR: w = a[i] ^ b[i];
                VALU_MIN: w = lt ? a[i] : b[i];
                VALU_MAX: w = lt ? b[i] : a[i];
                VALU_MV:  w = b[i];
                VALU_VID: w = word_t'(i);
                default:  w = old[i];
            endcase
            if (m[i]) begin
                r[i] = w;
            end
            bits[i] = m[i] && ((op == VALU_SEQ) ? (a[i] == b[i]) : lt);
            e = m[i] ? a[i] : pad;
            if (op == VALU_REDSUM) begin
                acc = acc + e;
            end else if (uns ? (acc < e) : ($signed(acc) < $signed(e))) begin
                acc = e;
            end
        end
        if (op == VALU_SEQ || op == VALU_SLT) begin
            r[0] = word_t'(bits);
        end
        if (op == VALU_REDSUM || op == VALU_REDMAX) begin
            r[0] = acc;
        end
        return r;
    endfunction

    // drives one instruction for one edge; keep=0 means it is expected to be dropped
    task automatic issue(input valuop_t op, input vreg_sel_t vd, input vreg_sel_t vs1,
                         input vreg_sel_t vs2, input logic rs1_en, input logic imm_en,
                         input logic [4:0] imm_v, input word_t scalar, input logic msk,
                         input logic uns, input logic keep);
        vec_t                 b;
        vec_t                 r;
        logic [NUM_LANES-1:0] m;
        m = msk ? shadow[0][0][NUM_LANES-1:0] : '1;
        for (int i = 0; i < NUM_LANES; i++) begin
            b[i] = imm_en ? {{27{imm_v[4]}}, imm_v} : (rs1_en ? scalar : shadow[vs1][i]);
        end
        if (keep) begin
            r = predict(op, shadow[vs2], b, shadow[vd], m, uns);
            shadow[vd] = r;
            exp_vd.push_back(vd);
            exp_res.push_back(r);
            exp_mask.push_back(m);
        end
        in_valid = 1'b1;
        valuop = op;
        vd_sel = vd;
        vs1_sel = vs1;
        vs2_sel = vs2;
        use_rs1 = rs1_en;
        use_imm = imm_en;
        imm = imm_v;
        rdat1 = scalar;
        mask_en = msk;
        is_unsigned = uns;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic op_vv(input valuop_t op, input vreg_sel_t vd, input vreg_sel_t vs1,
                         input vreg_sel_t vs2, input logic msk, input logic uns);
        issue(op, vd, vs1, vs2, 1'b0, 1'b0, 5'd0, '0, msk, uns, 1'b1);
    endtask

    task automatic op_vx(input valuop_t op, input vreg_sel_t vd, input vreg_sel_t vs2,
                         input word_t scalar, input logic msk, input logic uns);
        issue(op, vd, 5'd0, vs2, 1'b1, 1'b0, 5'd0, scalar, msk, uns, 1'b1);
    endtask

    task automatic op_vi(input valuop_t op, input vreg_sel_t vd, input vreg_sel_t vs2,
                         input logic [4:0] imm_v, input logic msk, input logic uns);
        issue(op, vd, 5'd0, vs2, 1'b0, 1'b1, imm_v, '0, msk, uns, 1'b1);
    endtask

    // wait for every expected result, then compare in issue order
    task automatic drain();
        int cycles;
        cycles = 0;
        while (got_vd.size() < exp_vd.size()) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout: %0d of %0d results arrived", got_vd.size(), exp_vd.size());
                fail_stop();
            end
            @(posedge clk);
            cycles++;
        end
        repeat (4) @(posedge clk);
        #1;
        assert (got_vd.size() == exp_vd.size()) else begin
            $display("got %0d results for %0d instructions", got_vd.size(), exp_vd.size());
            fail_stop();
        end
        while (exp_vd.size() > 0) begin
            check_value("out_vd", word_t'(exp_vd.pop_front()), word_t'(got_vd.pop_front()));
            check_value("out_lane_mask", word_t'(exp_mask.pop_front()),
                        word_t'(got_mask.pop_front()));
            for (int i = 0; i < NUM_LANES; i++) begin
                check_value($sformatf("out_result[%0d]", i), exp_res[0][i], got_res[0][i]);
            end
            void'(exp_res.pop_front());
            void'(got_res.pop_front());
        end
    endtask

    task automatic test_reset_state();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        op_vv(VALU_ADD, 5'd1, 5'd3, 5'd2, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_elementwise();
        word_t      s;
        logic [4:0] k_imm;
        valuop_t    op;
        op_vx(VALU_MV, 5'd3, 5'd0, next_rand(), 1'b0, 1'b0);
        op_vx(VALU_MV, 5'd4, 5'd0, next_rand(), 1'b0, 1'b0);
        op_vi(VALU_MV, 5'd5, 5'd0, rand_imm(), 1'b0, 1'b0);
        op_vv(VALU_VID, 5'd2, 5'd0, 5'd0, 1'b0, 1'b0);
        drain();
        // lane-varying sources built from vid
        op_vx(VALU_ADD, 5'd6, 5'd2, next_rand(), 1'b0, 1'b0);
        op_vv(VALU_SUB, 5'd7, 5'd2, 5'd4, 1'b0, 1'b0);
        op_vv(VALU_ADD, 5'd8, 5'd2, 5'd5, 1'b0, 1'b0);
        drain();
        for (int k = 0; k <= int'(VALU_MAX); k++) begin
            op = valuop_t'(k);
            s = next_rand();
            k_imm = rand_imm();
            op_vv(op, 5'd10, 5'd7, 5'd6, 1'b0, 1'b0);
            op_vx(op, 5'd11, 5'd6, s, 1'b0, 1'b0);
            op_vi(op, 5'd12, 5'd8, k_imm, 1'b0, 1'b0);
            if (op == VALU_MIN || op == VALU_MAX) begin
                op_vv(op, 5'd13, 5'd7, 5'd6, 1'b0, 1'b1);
                op_vx(op, 5'd14, 5'd6, s, 1'b0, 1'b1);
                op_vi(op, 5'd15, 5'd8, k_imm, 1'b0, 1'b1);
            end
            drain();
        end
    endtask

    task automatic test_compare_mask();
        op_vi(VALU_AND, 5'd20, 5'd2, 5'd1, 1'b0, 1'b0);
        op_vx(VALU_SLT, 5'd21, 5'd2, 32'd2, 1'b0, 1'b0);
        drain();
        // odd lanes become active
        op_vi(VALU_SEQ, 5'd0, 5'd20, 5'd1, 1'b0, 1'b0);
        drain();
        op_vv(VALU_ADD, 5'd12, 5'd7, 5'd6, 1'b1, 1'b0);
        op_vx(VALU_SLT, 5'd22, 5'd6, next_rand(), 1'b1, 1'b1);
        op_vi(VALU_MV, 5'd23, 5'd0, rand_imm(), 1'b1, 1'b0);
        drain();
    endtask

    task automatic test_reductions();
        for (int u = 0; u < 2; u++) begin
            for (int mk = 0; mk < 2; mk++) begin
                op_vv(VALU_REDSUM, 5'd24, 5'd7, 5'd6, mk[0], u[0]);
                op_vv(VALU_REDMAX, 5'd25, 5'd7, 5'd6, mk[0], u[0]);
                op_vx(VALU_REDMAX, 5'd26, 5'd8, next_rand(), mk[0], u[0]);
                drain();
            end
        end
        // empty mask leaves only the start value
        op_vi(VALU_MV, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
        drain();
        op_vx(VALU_REDMAX, 5'd27, 5'd6, next_rand(), 1'b1, 1'b0);
        op_vv(VALU_REDSUM, 5'd28, 5'd7, 5'd6, 1'b1, 1'b0);
        drain();
    endtask

    task automatic test_pipeline_stall();
        op_vv(VALU_ADD, 5'd10, 5'd7, 5'd6, 1'b0, 1'b0);
        op_vv(VALU_SUB, 5'd11, 5'd7, 5'd6, 1'b0, 1'b0);
        op_vx(VALU_XOR, 5'd12, 5'd6, next_rand(), 1'b0, 1'b0);
        // in_valid stays high on a junk op while stalled
        stall = 1'b1;
        in_valid = 1'b1;
        valuop = VALU_VID;
        vd_sel = 5'd30;
        use_rs1 = 1'b0;
        use_imm = 1'b0;
        mask_en = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        stall = 1'b0;
        in_valid = 1'b0;
        op_vi(VALU_OR, 5'd13, 5'd8, rand_imm(), 1'b0, 1'b0);
        op_vv(VALU_MAX, 5'd14, 5'd7, 5'd6, 1'b0, 1'b1);
        op_vv(VALU_VID, 5'd15, 5'd0, 5'd0, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_flush();
        op_vx(VALU_MV, 5'd25, 5'd0, next_rand(), 1'b0, 1'b0);
        op_vx(VALU_MV, 5'd26, 5'd0, next_rand(), 1'b0, 1'b0);
        op_vx(VALU_MV, 5'd27, 5'd0, next_rand(), 1'b0, 1'b0);
        drain();
        issue(VALU_VID, 5'd25, 5'd0, 5'd0, 1'b0, 1'b0, 5'd0, '0, 1'b0, 1'b0, 1'b0);
        issue(VALU_ADD, 5'd26, 5'd7, 5'd6, 1'b0, 1'b0, 5'd0, '0, 1'b0, 1'b0, 1'b0);
        // flush on the edge that samples the third one
        flush = 1'b1;
        issue(VALU_XOR, 5'd27, 5'd0, 5'd6, 1'b1, 1'b0, 5'd0, next_rand(), 1'b0, 1'b0, 1'b0);
        flush = 1'b0;
        drain();
        op_vi(VALU_OR, 5'd25, 5'd25, 5'd0, 1'b0, 1'b0);
        op_vi(VALU_OR, 5'd26, 5'd26, 5'd0, 1'b0, 1'b0);
        op_vi(VALU_OR, 5'd27, 5'd27, 5'd0, 1'b0, 1'b0);
        drain();
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        valuop = VALU_ADD;
        vd_sel = '0;
        vs1_sel = '0;
        vs2_sel = '0;
        use_rs1 = 1'b0;
        use_imm = 1'b0;
        imm = '0;
        rdat1 = '0;
        mask_en = 1'b0;
        is_unsigned = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        test_reset_state();
        test_elementwise();
        test_compare_mask();
        test_reductions();
        test_pipeline_stall();
        test_flush();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* logic/rvv_ex_pkg.sv */
package rvv_ex_pkg;

    // one 32-bit vector element
    typedef logic [31:0] word_t;

    // register index into a 32-entry bank
    typedef logic [4:0] vreg_sel_t;

    // execute operation
    typedef enum logic [3:0] {
        VALU_ADD,
        VALU_SUB,
        VALU_AND,
        VALU_OR,
        VALU_XOR,
        VALU_MIN,
        VALU_MAX,
        // compares produce one mask bit per lane
        VALU_SEQ,
        VALU_SLT,
        // broadcast of scalar or immediate
        VALU_MV,
        VALU_VID,
        // cross-lane folds
        VALU_REDSUM,
        VALU_REDMAX
    } valuop_t;

    // how the result stage writes back
    typedef enum logic [1:0] {
        // each active lane gets its own word
        WB_LANES,
        // packed compare bits into lane 0
        WB_MASK,
        // reduction result into lane 0 only
        WB_SCALAR
    } wb_kind_t;

endpackage

/* logic/vector_bank.sv */
module vector_bank import rvv_ex_pkg::*; (
    input  logic      CLK,
    input  logic      reset,
    input  vreg_sel_t rs1_sel,
    input  vreg_sel_t rs2_sel,
    input  vreg_sel_t rs3_sel,
    input  logic      wen,
    input  vreg_sel_t wsel,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2,
    output word_t     rdata3,
    output word_t     v0_word
);

    word_t regs [32];

    // single write port, whole bank cleared on reset
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wsel] <= wdata;
        end
    end

    // combinational reads
    assign rdata1 = regs[rs1_sel];
    assign rdata2 = regs[rs2_sel];
    assign rdata3 = regs[rs3_sel];

    // v0 is always visible for mask decode
    assign v0_word = regs[0];

    // writeback data comes from the result stage two cycles downstream
    a_wdata_known: assert property (
        @(posedge CLK) disable iff (reset)
        wen |-> !$isunknown(wdata)
    );

endmodule

/* logic/vector_ex_datapath.sv */
module vector_ex_datapath import rvv_ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  in_valid,
    input  valuop_t               valuop,
    input  vreg_sel_t             vd_sel,
    input  vreg_sel_t             vs1_sel,
    input  vreg_sel_t             vs2_sel,
    input  logic                  use_rs1,
    input  logic                  use_imm,
    input  logic [4:0]            imm,
    input  word_t                 rdat1,
    input  logic                  mask_en,
    input  logic                  is_unsigned,
    input  logic                  stall,
    input  logic                  flush,
    output logic                  out_valid,
    output vreg_sel_t             out_vd,
    output word_t [NUM_LANES-1:0] out_result,
    output logic [NUM_LANES-1:0]  out_lane_mask
);

    // operand to execute
    logic                  s1_valid;
    valuop_t               s1_valuop;
    wb_kind_t              s1_wb_kind;
    logic                  s1_is_unsigned;
    vreg_sel_t             s1_vd;
    word_t [NUM_LANES-1:0] s1_opa;
    word_t [NUM_LANES-1:0] s1_opb;
    word_t [NUM_LANES-1:0] s1_opc;
    logic [NUM_LANES-1:0]  s1_lane_mask;

    // execute to result
    logic                  s2_valid;
    wb_kind_t              s2_wb_kind;
    vreg_sel_t             s2_vd;
    word_t [NUM_LANES-1:0] s2_lane_res;
    logic [NUM_LANES-1:0]  s2_cmp_bits;
    word_t                 s2_red_res;
    word_t [NUM_LANES-1:0] s2_old_vd;
    logic [NUM_LANES-1:0]  s2_lane_mask;

    // writeback into the banks
    logic [NUM_LANES-1:0]  bank_wen;
    vreg_sel_t             bank_wsel;
    word_t [NUM_LANES-1:0] bank_wdata;

    voperand_stage #(
        .NUM_LANES (NUM_LANES)
    ) i_operand (
        .CLK            (CLK),
        .reset          (reset),
        .in_valid       (in_valid),
        .valuop         (valuop),
        .vd_sel         (vd_sel),
        .vs1_sel        (vs1_sel),
        .vs2_sel        (vs2_sel),
        .use_rs1        (use_rs1),
        .use_imm        (use_imm),
        .imm            (imm),
        .rdat1          (rdat1),
        .mask_en        (mask_en),
        .is_unsigned    (is_unsigned),
        .stall          (stall),
        .flush          (flush),
        .bank_wen       (bank_wen),
        .bank_wsel      (bank_wsel),
        .bank_wdata     (bank_wdata),
        .s1_valid       (s1_valid),
        .s1_valuop      (s1_valuop),
        .s1_wb_kind     (s1_wb_kind),
        .s1_is_unsigned (s1_is_unsigned),
        .s1_vd          (s1_vd),
        .s1_opa         (s1_opa),
        .s1_opb         (s1_opb),
        .s1_opc         (s1_opc),
        .s1_lane_mask   (s1_lane_mask)
    );

    vexecute_stage #(
        .NUM_LANES (NUM_LANES)
    ) i_execute (
        .CLK            (CLK),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .s1_valid       (s1_valid),
        .s1_valuop      (s1_valuop),
        .s1_wb_kind     (s1_wb_kind),
        .s1_is_unsigned (s1_is_unsigned),
        .s1_vd          (s1_vd),
        .s1_opa         (s1_opa),
        .s1_opb         (s1_opb),
        .s1_opc         (s1_opc),
        .s1_lane_mask   (s1_lane_mask),
        .s2_valid       (s2_valid),
        .s2_wb_kind     (s2_wb_kind),
        .s2_vd          (s2_vd),
        .s2_lane_res    (s2_lane_res),
        .s2_cmp_bits    (s2_cmp_bits),
        .s2_red_res     (s2_red_res),
        .s2_old_vd      (s2_old_vd),
        .s2_lane_mask   (s2_lane_mask)
    );

    vresult_stage #(
        .NUM_LANES (NUM_LANES)
    ) i_result (
        .CLK           (CLK),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .s2_valid      (s2_valid),
        .s2_wb_kind    (s2_wb_kind),
        .s2_vd         (s2_vd),
        .s2_lane_res   (s2_lane_res),
        .s2_cmp_bits   (s2_cmp_bits),
        .s2_red_res    (s2_red_res),
        .s2_old_vd     (s2_old_vd),
        .s2_lane_mask  (s2_lane_mask),
        .bank_wen      (bank_wen),
        .bank_wsel     (bank_wsel),
        .bank_wdata    (bank_wdata),
        .out_valid     (out_valid),
        .out_vd        (out_vd),
        .out_result    (out_result),
        .out_lane_mask (out_lane_mask)
    );

endmodule

/* logic/vexecute_stage.sv */
module vexecute_stage import rvv_ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  s1_valid,
    input  valuop_t               s1_valuop,
    input  wb_kind_t              s1_wb_kind,
    input  logic                  s1_is_unsigned,
    input  vreg_sel_t             s1_vd,
    input  word_t [NUM_LANES-1:0] s1_opa,
    input  word_t [NUM_LANES-1:0] s1_opb,
    input  word_t [NUM_LANES-1:0] s1_opc,
    input  logic [NUM_LANES-1:0]  s1_lane_mask,
    output logic                  s2_valid,
    output wb_kind_t              s2_wb_kind,
    output vreg_sel_t             s2_vd,
    output word_t [NUM_LANES-1:0] s2_lane_res,
    output logic [NUM_LANES-1:0]  s2_cmp_bits,
    output word_t                 s2_red_res,
    output word_t [NUM_LANES-1:0] s2_old_vd,
    output logic [NUM_LANES-1:0]  s2_lane_mask
);

    word_t [NUM_LANES-1:0] lane_res;
    logic [NUM_LANES-1:0]  cmp_bits;
    word_t                 red_res;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        localparam word_t LANE_IDX = word_t'(i);

        vlane_alu i_alu (
            .opa         (s1_opa[i]),
            .opb         (s1_opb[i]),
            .valuop      (s1_valuop),
            .is_unsigned (s1_is_unsigned),
            .lane_index  (LANE_IDX),
            .res         (lane_res[i]),
            .cmp_bit     (cmp_bits[i])
        );
    end

    // start value is lane 0 of the second operand
    vreduction_tree #(
        .NUM_LANES (NUM_LANES)
    ) i_red (
        .data        (s1_opa),
        .lane_mask   (s1_lane_mask),
        .start       (s1_opb[0]),
        .valuop      (s1_valuop),
        .is_unsigned (s1_is_unsigned),
        .red_res     (red_res)
    );

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            s2_wb_kind   <= s1_wb_kind;
            s2_vd        <= s1_vd;
            s2_lane_res  <= lane_res;
            s2_cmp_bits  <= cmp_bits;
            s2_red_res   <= red_res;
            s2_old_vd    <= s1_opc;
            s2_lane_mask <= s1_lane_mask;
        end
    end

endmodule

/* logic/vlane_alu.sv */
module vlane_alu import rvv_ex_pkg::*; (
    input  word_t   opa,
    input  word_t   opb,
    input  valuop_t valuop,
    input  logic    is_unsigned,
    input  word_t   lane_index,
    output word_t   res,
    output logic    cmp_bit
);

    logic lt;

    // shared less-than for min, max and slt
    assign lt = is_unsigned ? (opa < opb) : ($signed(opa) < $signed(opb));

    always_comb begin
        res     = '0;
        cmp_bit = 1'b0;
        case (valuop)
            VALU_ADD: res = opa + opb;
            VALU_SUB: res = opa - opb;
            VALU_AND: res = opa & opb;
            VALU_OR:  res = opa | opb;
            VALU_XOR: res = opa ^ opb;
            VALU_MIN: res = lt ? opa : opb;
            VALU_MAX: res = lt ? opb : opa;
            VALU_SEQ: begin
                cmp_bit = (opa == opb);
            end
            VALU_SLT: begin
                cmp_bit = lt;
            end
            VALU_MV:  res = opb;
            VALU_VID: res = lane_index;
            // reductions are handled by the tree
            default:  res = '0;
        endcase
    end

endmodule

/* logic/voperand_stage.sv */
module voperand_stage import rvv_ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic                        in_valid,
    input  valuop_t                     valuop,
    input  vreg_sel_t                   vd_sel,
    input  vreg_sel_t                   vs1_sel,
    input  vreg_sel_t                   vs2_sel,
    input  logic                        use_rs1,
    input  logic                        use_imm,
    input  logic [4:0]                  imm,
    input  word_t                       rdat1,
    input  logic                        mask_en,
    input  logic                        is_unsigned,
    input  logic                        stall,
    input  logic                        flush,
    input  logic [NUM_LANES-1:0]        bank_wen,
    input  vreg_sel_t                   bank_wsel,
    input  word_t [NUM_LANES-1:0]       bank_wdata,
    output logic                        s1_valid,
    output valuop_t                     s1_valuop,
    output wb_kind_t                    s1_wb_kind,
    output logic                        s1_is_unsigned,
    output vreg_sel_t                   s1_vd,
    output word_t [NUM_LANES-1:0]       s1_opa,
    output word_t [NUM_LANES-1:0]       s1_opb,
    output word_t [NUM_LANES-1:0]       s1_opc,
    output logic [NUM_LANES-1:0]        s1_lane_mask
);

    word_t [NUM_LANES-1:0] vs1_dat;
    word_t [NUM_LANES-1:0] vs2_dat;
    word_t [NUM_LANES-1:0] vd_dat;
    word_t [NUM_LANES-1:0] opb;
    word_t                 v0_words [NUM_LANES];
    word_t                 imm_ext;
    logic [NUM_LANES-1:0]  lane_mask;
    wb_kind_t              wb_kind;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_bank
        vector_bank i_bank (
            .CLK     (CLK),
            .reset   (reset),
            .rs1_sel (vs1_sel),
            .rs2_sel (vs2_sel),
            .rs3_sel (vd_sel),
            .wen     (bank_wen[i]),
            .wsel    (bank_wsel),
            .wdata   (bank_wdata[i]),
            .rdata1  (vs1_dat[i]),
            .rdata2  (vs2_dat[i]),
            .rdata3  (vd_dat[i]),
            .v0_word (v0_words[i])
        );
    end

    // mask bits live in the low bits of lane 0's v0
    assign lane_mask = mask_en ? v0_words[0][NUM_LANES-1:0] : '1;

    assign imm_ext = {{27{imm[4]}}, imm};

    // immediate wins over scalar, scalar over vs1
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (use_imm) begin
                opb[i] = imm_ext;
            end else if (use_rs1) begin
                opb[i] = rdat1;
            end else begin
                opb[i] = vs1_dat[i];
            end
        end
    end

    always_comb begin
        case (valuop)
            VALU_SEQ, VALU_SLT:       wb_kind = WB_MASK;
            VALU_REDSUM, VALU_REDMAX: wb_kind = WB_SCALAR;
            default:                  wb_kind = WB_LANES;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            s1_valuop      <= valuop;
            s1_wb_kind     <= wb_kind;
            s1_is_unsigned <= is_unsigned;
            s1_vd          <= vd_sel;
            s1_opa         <= vs2_dat;
            s1_opb         <= opb;
            s1_opc         <= vd_dat;
            s1_lane_mask   <= lane_mask;
        end
    end

    a_one_scalar_source: assert property (
        @(posedge CLK) disable iff (reset)
        in_valid |-> !(use_imm && use_rs1)
    );

endmodule

/* logic/vreduction_tree.sv */
module vreduction_tree import rvv_ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  word_t [NUM_LANES-1:0] data,
    input  logic [NUM_LANES-1:0]  lane_mask,
    input  word_t                 start,
    input  valuop_t               valuop,
    input  logic                  is_unsigned,
    output word_t                 red_res
);

    word_t [NUM_LANES-1:0] acc;
    word_t                 ident;
    logic                  is_max;

    function automatic word_t combine(input word_t a, input word_t b,
                                      input logic max_op, input logic uns);
        logic a_lt_b;
        a_lt_b = uns ? (a < b) : ($signed(a) < $signed(b));
        if (max_op) begin
            return a_lt_b ? b : a;
        end
        return a + b;
    endfunction

    assign is_max = (valuop == VALU_REDMAX);

    // identity for masked-off lanes
    assign ident = (is_max && !is_unsigned) ? 32'h8000_0000 : '0;

    // pad, then fold pairwise; in-place is safe since writes trail reads
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            acc[i] = lane_mask[i] ? data[i] : ident;
        end
        for (int w = NUM_LANES / 2; w >= 1; w = w / 2) begin
            for (int j = 0; j < w; j++) begin
                acc[j] = combine(acc[2*j], acc[2*j+1], is_max, is_unsigned);
            end
        end
        red_res = combine(acc[0], start, is_max, is_unsigned);
    end

endmodule

/* logic/vresult_stage.sv */
module vresult_stage import rvv_ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  s2_valid,
    input  wb_kind_t              s2_wb_kind,
    input  vreg_sel_t             s2_vd,
    input  word_t [NUM_LANES-1:0] s2_lane_res,
    input  logic [NUM_LANES-1:0]  s2_cmp_bits,
    input  word_t                 s2_red_res,
    input  word_t [NUM_LANES-1:0] s2_old_vd,
    input  logic [NUM_LANES-1:0]  s2_lane_mask,
    output logic [NUM_LANES-1:0]  bank_wen,
    output vreg_sel_t             bank_wsel,
    output word_t [NUM_LANES-1:0] bank_wdata,
    output logic                  out_valid,
    output vreg_sel_t             out_vd,
    output word_t [NUM_LANES-1:0] out_result,
    output logic [NUM_LANES-1:0]  out_lane_mask
);

    word_t [NUM_LANES-1:0] final_vec;
    logic [NUM_LANES-1:0]  lane_wr;
    logic                  commit;

    // start from the old vd and overwrite what the op produces
    always_comb begin
        final_vec = s2_old_vd;
        lane_wr   = '0;
        case (s2_wb_kind)
            WB_MASK: begin
                final_vec[0] = word_t'(s2_cmp_bits & s2_lane_mask);
                lane_wr[0]   = 1'b1;
            end
            WB_SCALAR: begin
                final_vec[0] = s2_red_res;
                lane_wr[0]   = 1'b1;
            end
            default: begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (s2_lane_mask[i]) begin
                        final_vec[i] = s2_lane_res[i];
                    end
                end
                lane_wr = s2_lane_mask;
            end
        endcase
    end

    // a flushed or stalled instruction must not touch the banks
    assign commit     = s2_valid && !stall && !flush;
    assign bank_wen   = {NUM_LANES{commit}} & lane_wr;
    assign bank_wsel  = s2_vd;
    assign bank_wdata = final_vec;

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            out_vd        <= s2_vd;
            out_result    <= final_vec;
            out_lane_mask <= s2_lane_mask;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the vector execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_vector_ex -f vector_ex.f -o sim_vector_ex
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_vector_ex > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* vector_ex.f */
logic/rvv_ex_pkg.sv
logic/vector_bank.sv
logic/voperand_stage.sv
logic/vlane_alu.sv
logic/vreduction_tree.sv
logic/vexecute_stage.sv
logic/vresult_stage.sv
logic/vector_ex_datapath.sv
dv/tb_vector_ex.sv
